// ==== design/ks10_settings.svh ====
/* KS10 bus settings
   Memory size, bus timeout, controller numbers and device register count */

`ifndef KS10_SETTINGS_SVH
`define KS10_SETTINGS_SVH

// Main memory depth in 36-bit words
`define MEM_WORDS   1024

// Cycles the arbiter waits on a target ack
`define BUS_TIMEOUT 16

// Controller numbers of the two IO bridges
`define CTL_NUM1    4'd1
`define CTL_NUM3    4'd3

// 18-bit registers per bridge, register 0 is the CSR
`define DEV_REGS    8

`endif

// ==== design/ks10Pkg.sv ====
/* KS10 bus package
   Address word views, request and response words, CSR bit positions */

`default_nettype none

package ks10Pkg;

   ////////////////////
   // Address word

   // Flags at the top of every address word
   typedef struct packed {
      logic        rd;        // Read request
      logic        wr;        // Write request
      logic        io;        // IO space access
      logic [10:0] spare;     // Ignored
   } busFlags_t;

   // One address word, decoded as memory or as IO
   typedef union packed {
      struct packed {
         busFlags_t   flags;
         logic [21:0] wordAddr;   // Memory word address
      } memView;
      struct packed {
         busFlags_t   flags;
         logic [3:0]  ctlNum;     // Controller number
         logic [17:0] regAddr;    // Device register address
      } ioView;
   } busAddr_t;

   ////////////////////
   // Bus words

   typedef struct packed {
      busAddr_t    addr;
      logic [35:0] data;      // Write data
   } busReq_t;

   typedef struct packed {
      logic [35:0] data;      // Read data
      logic        nxm;       // No target answered
   } busRsp_t;

   // Bit n-1 is interrupt level n
   typedef logic [6:0] intrVec_t;

   // CSR bit positions
   localparam int csrLevelLsb  = 0;
   localparam int csrLevelMsb  = 2;   // Level 1..7, zero is off
   localparam int csrIntEnable = 6;
   localparam int csrDone      = 7;

endpackage

`default_nettype wire

// ==== design/busMemory.sv ====
/* Bus memory
   Main memory target on the four-phase bus, silent on out-of-range addresses */

`default_nettype none
`timescale 1ns/1ps

`include "ks10_settings.svh"

module busMemory (
   input  logic             clk,
   input  logic             reset,
   input  logic             tgtReq,    // Request from arbiter
   input  ks10Pkg::busReq_t request,   // Shared address and write data
   output logic             tgtAck,    // Ack to arbiter
   output logic [35:0]      rdData     // Read data to arbiter
);

   localparam int idxBits = $clog2(`MEM_WORDS);

   logic [35:0]        mem [0:`MEM_WORDS-1];
   logic               inRange;   // Word address inside the array
   logic               start;     // First cycle of a served access
   logic [idxBits-1:0] idx;

   ////////////////////
   // Decode

   assign inRange = request.addr.memView.wordAddr < `MEM_WORDS;
   assign idx     = request.addr.memView.wordAddr[idxBits-1:0];
   assign start   = tgtReq && !tgtAck && inRange;   // Ack not up yet

   ////////////////////
   // Handshake

   // Ack follows request one cycle later, never for a bad address
   always_ff @(posedge clk) begin
      if (reset) begin
         tgtAck <= 1'b0;
      end else begin
         tgtAck <= tgtReq && inRange;
      end
   end

   // Array access on the first request cycle only
   always_ff @(posedge clk) begin
      if (start) begin
         if (request.addr.memView.flags.wr) begin
            mem[idx] <= request.data;
         end
         rdData <= request.addr.memView.flags.rd ? mem[idx] : 36'd0;   // Old word on read
      end
   end

   ////////////////////
   // Checks

   // Arbiter holds a served request until the ack comes back
   reqHeld: assert property (@(posedge clk) disable iff (reset)
      start |=> tgtReq);

endmodule

`default_nettype wire

// ==== design/ioBridge.sv ====
/* IO bridge
   Device register bank with a CSR that drives one interrupt level */

`default_nettype none
`timescale 1ns/1ps

`include "ks10_settings.svh"

module ioBridge #(
   parameter logic [3:0] ctlNum = `CTL_NUM1     // Controller number of this bridge
) (
   input  logic              clk,
   input  logic              reset,
   input  logic              tgtReq,    // Request from arbiter
   input  ks10Pkg::busReq_t  request,   // Shared address and write data
   output logic              tgtAck,    // Ack to arbiter
   output logic [35:0]       rdData,    // Zero-extended register value
   output ks10Pkg::intrVec_t intr       // One bit per level
);

   localparam int regBits = $clog2(`DEV_REGS);

   logic [17:0]        devReg [0:`DEV_REGS-1];
   logic               inRange;   // Register exists
   logic               start;     // First cycle of a served access
   logic [regBits-1:0] regIdx;
   logic [17:0]        csr;
   logic [2:0]         level;     // CSR priority level

   ////////////////////
   // Decode

   // Controller already matched by the arbiter, only the range is left
   assign inRange = request.addr.ioView.regAddr < `DEV_REGS;
   assign regIdx  = request.addr.ioView.regAddr[regBits-1:0];
   assign start   = tgtReq && !tgtAck && inRange;

   ////////////////////
   // Registers

   // Ack and device registers, all cleared by reset
   always_ff @(posedge clk) begin
      if (reset) begin
         tgtAck <= 1'b0;
         for (int i = 0; i < `DEV_REGS; i++) begin
            devReg[i] <= 18'd0;
         end
      end else begin
         tgtAck <= tgtReq && inRange;   // Stays low above DEV_REGS
         if (start && request.addr.ioView.flags.wr) begin
            devReg[regIdx] <= request.data[17:0];   // Low half only
         end
      end
   end

   // Read data captured on the first request cycle
   always_ff @(posedge clk) begin
      if (start) begin
         if (request.addr.ioView.flags.rd) begin
            rdData <= {18'd0, devReg[regIdx]};
         end else begin
            rdData <= 36'd0;
         end
      end
   end

   ////////////////////
   // Interrupt

   assign csr   = devReg[0];
   assign level = csr[ks10Pkg::csrLevelMsb:ks10Pkg::csrLevelLsb];

   // Request at the CSR level when enabled and done
   always_comb begin
      intr = '0;
      if (csr[ks10Pkg::csrIntEnable] && csr[ks10Pkg::csrDone] && level != 3'd0) begin
         intr[level - 3'd1] = 1'b1;   // Level n on bit n-1
      end
   end

   ////////////////////
   // Checks

   // Arbiter keeps the latched request fixed for the whole handshake
   reqStable: assert property (@(posedge clk) disable iff (reset)
      tgtReq && $past(tgtReq) |-> $stable(request));

   // Only an IO access for this controller may select the bridge
   ctlMatch: assert property (@(posedge clk) disable iff (reset)
      $rose(tgtReq) |-> request.addr.ioView.flags.io &&
                        request.addr.ioView.ctlNum == ctlNum);

endmodule

`default_nettype wire

// ==== design/busArbiter.sv ====
/* Bus arbiter
   Decodes the address word, runs the target handshake with timeout, merges results */

`default_nettype none
`timescale 1ns/1ps

`include "ks10_settings.svh"

module busArbiter (
   input  logic              clk,
   input  logic              reset,
   // Master side
   input  logic              req,          // Master request
   input  ks10Pkg::busReq_t  request,      // Master address and data
   output logic              ack,          // Ack to master
   output ks10Pkg::busRsp_t  response,     // Registered response
   // Memory
   output logic              memReq,
   input  logic              memAck,
   input  logic [35:0]       memData,
   // IO bridge 1
   output logic              io1Req,
   input  logic              io1Ack,
   input  logic [35:0]       io1Data,
   // IO bridge 3
   output logic              io3Req,
   input  logic              io3Ack,
   input  logic [35:0]       io3Data,
   // Interrupts
   input  ks10Pkg::intrVec_t io1Intr,
   input  ks10Pkg::intrVec_t io3Intr,
   // Shared target side
   output ks10Pkg::busReq_t  busRequest,   // Latched request to all targets
   output ks10Pkg::intrVec_t busIntr       // Merged interrupt vector
);

   localparam int timerBits = $clog2(`BUS_TIMEOUT + 1);

   // FSM states
   localparam logic [1:0] stIdle    = 2'd0;
   localparam logic [1:0] stWaitAck = 2'd1;   // Target request up
   localparam logic [1:0] stRespond = 2'd2;   // Ack up, wait for req low
   localparam logic [1:0] stRelease = 2'd3;   // Wait for target ack low

   logic [1:0]           state;
   logic [timerBits-1:0] timer;
   logic                 isIo;        // IO flag of the incoming word
   logic                 hitIo1;
   logic                 hitIo3;
   logic                 selAck;      // Ack of the requested target
   logic                 anyAck;
   logic                 timeUp;
   logic [35:0]          selData;

   ////////////////////
   // Decode

   // Same word seen through both views
   assign isIo   = request.addr.memView.flags.io;
   assign hitIo1 = isIo && (request.addr.ioView.ctlNum == `CTL_NUM1);
   assign hitIo3 = isIo && (request.addr.ioView.ctlNum == `CTL_NUM3);

   // Target request doubles as target select
   assign selAck = (memReq & memAck) | (io1Req & io1Ack) | (io3Req & io3Ack);
   assign anyAck = memAck | io1Ack | io3Ack;
   assign timeUp = (timer == timerBits'(`BUS_TIMEOUT - 1));

   always_comb begin
      selData = 36'd0;
      if (memReq) selData = memData;
      if (io1Req) selData = io1Data;
      if (io3Req) selData = io3Data;
   end

   ////////////////////
   // Sequencer

   always_ff @(posedge clk) begin
      if (reset) begin
         state  <= stIdle;
         ack    <= 1'b0;
         memReq <= 1'b0;
         io1Req <= 1'b0;
         io3Req <= 1'b0;
         timer  <= '0;
      end else begin
         case (state)
            stIdle: if (req) begin
               memReq <= !isIo;    // Unknown controller raises nothing
               io1Req <= hitIo1;
               io3Req <= hitIo3;
               timer  <= '0;
               state  <= stWaitAck;
            end
            stWaitAck: if (selAck || timeUp) begin
               memReq <= 1'b0;     // Release the target
               io1Req <= 1'b0;
               io3Req <= 1'b0;
               ack    <= 1'b1;
               state  <= stRespond;
            end else begin
               timer <= timer + 1'b1;
            end
            stRespond: if (!req) begin
               if (anyAck) begin
                  state <= stRelease;   // Target still finishing
               end else begin
                  ack   <= 1'b0;
                  state <= stIdle;
               end
            end
            default: if (!anyAck) begin
               ack   <= 1'b0;
               state <= stIdle;
            end
         endcase
      end
   end

   // Payload latches, held until the next transaction
   always_ff @(posedge clk) begin
      if (state == stIdle && req) begin
         busRequest <= request;
      end
      if (state == stWaitAck) begin
         if (selAck) begin
            response.data <= selData;
            response.nxm  <= 1'b0;
         end else if (timeUp) begin
            response.data <= 36'd0;   // Nobody home
            response.nxm  <= 1'b1;
         end
      end
   end

   // Both bridges share the interrupt lines
   assign busIntr = io1Intr | io3Intr;

   ////////////////////
   // Checks

   // Targets answer one at a time
   oneTargetAck: assert property (@(posedge clk) disable iff (reset)
      $onehot0({memAck, io1Ack, io3Ack}));

   // Four-phase order on the master side
   ackAfterReq: assert property (@(posedge clk) disable iff (reset)
      $fell(ack) |-> !$past(req));

endmodule

`default_nettype wire

// ==== design/ks10Bus.sv ====
/* KS10 backplane top
   Arbiter with main memory and IO bridges 1 and 3 */

`default_nettype none
`timescale 1ns/1ps

`include "ks10_settings.svh"

module ks10Bus (
   input  logic              clk,
   input  logic              reset,
   input  logic              req,        // Master request
   input  ks10Pkg::busReq_t  request,    // Master address and data
   output logic              ack,        // Ack to master
   output ks10Pkg::busRsp_t  response,   // Read data and nxm
   output ks10Pkg::intrVec_t busIntr     // Merged interrupts
);

   ////////////////////
   // Target wiring

   ks10Pkg::busReq_t  busRequest;   // Fans out to all targets
   logic              memReq;
   logic              memAck;
   logic [35:0]       memData;
   logic              io1Req;
   logic              io1Ack;
   logic [35:0]       io1Data;
   ks10Pkg::intrVec_t io1Intr;
   logic              io3Req;
   logic              io3Ack;
   logic [35:0]       io3Data;
   ks10Pkg::intrVec_t io3Intr;

   busArbiter uArbiter (
      .clk        (clk),
      .reset      (reset),
      .req        (req),
      .request    (request),
      .ack        (ack),
      .response   (response),
      .memReq     (memReq),
      .memAck     (memAck),
      .memData    (memData),
      .io1Req     (io1Req),
      .io1Ack     (io1Ack),
      .io1Data    (io1Data),
      .io3Req     (io3Req),
      .io3Ack     (io3Ack),
      .io3Data    (io3Data),
      .io1Intr    (io1Intr),
      .io3Intr    (io3Intr),
      .busRequest (busRequest),
      .busIntr    (busIntr)
   );

   busMemory uMemory (
      .clk     (clk),
      .reset   (reset),
      .tgtReq  (memReq),
      .request (busRequest),
      .tgtAck  (memAck),
      .rdData  (memData)
   );

   // Bridges side by side, arbiter merges them
   ioBridge #(.ctlNum(`CTL_NUM1)) uBridge1 (
      .clk     (clk),
      .reset   (reset),
      .tgtReq  (io1Req),
      .request (busRequest),
      .tgtAck  (io1Ack),
      .rdData  (io1Data),
      .intr    (io1Intr)
   );

   ioBridge #(.ctlNum(`CTL_NUM3)) uBridge3 (
      .clk     (clk),
      .reset   (reset),
      .tgtReq  (io3Req),
      .request (busRequest),
      .tgtAck  (io3Ack),
      .rdData  (io3Data),
      .intr    (io3Intr)
   );

endmodule

`default_nettype wire

// ==== sim/ks10BusTb.sv ====
/* KS10 bus testbench
   Four-phase master with a shadow model of memory, bridges and interrupts */

`default_nettype none
`timescale 1ns/1ps

`include "ks10_settings.svh"

module ks10BusTb;

   localparam int numMem = 20;   // Random memory words per pass
   localparam int numTrans = 2 * numMem + 4 * `DEV_REGS + 5 + 3 + 2 * `DEV_REGS + numMem;
   localparam int cycleLimit = numTrans * (`BUS_TIMEOUT + 8) + 100;

   logic              clk;
   logic              reset;
   logic              req;
   ks10Pkg::busReq_t  request;
   logic              ack;
   ks10Pkg::busRsp_t  response;
   ks10Pkg::intrVec_t busIntr;

   // Shadow state
   logic [35:0] shadowMem [0:`MEM_WORDS-1];
   logic [17:0] shadowIo1 [0:`DEV_REGS-1];
   logic [17:0] shadowIo3 [0:`DEV_REGS-1];
   int          memAddrs [$];          // Words written so far
   ks10Pkg::busRsp_t expRspQ [$];      // Pending expected responses

   integer      seed;
   int          cycles;
   logic        ackPrev;
   logic        ackRise;

   ks10Bus uut (
      .clk      (clk),
      .reset    (reset),
      .req      (req),
      .request  (request),
      .ack      (ack),
      .response (response),
      .busIntr  (busIntr)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;   // 100 ns period
   end

   ////////////////////
   // Reference model

   function automatic ks10Pkg::busRsp_t refResponse(input ks10Pkg::busReq_t r);
      ks10Pkg::busRsp_t rsp;
      logic [17:0]      regVal;
      rsp = '{data: 36'd0, nxm: 1'b1};   // Default is nobody home
      if (!r.addr.memView.flags.io) begin
         if (r.addr.memView.wordAddr < `MEM_WORDS) begin
            rsp.nxm  = 1'b0;
            rsp.data = r.addr.memView.flags.rd ? shadowMem[r.addr.memView.wordAddr] : 36'd0;
         end
      end else if (r.addr.ioView.regAddr < `DEV_REGS &&
                   (r.addr.ioView.ctlNum == `CTL_NUM1 || r.addr.ioView.ctlNum == `CTL_NUM3)) begin
         if (r.addr.ioView.ctlNum == `CTL_NUM1) begin
            regVal = shadowIo1[r.addr.ioView.regAddr];
         end else begin
            regVal = shadowIo3[r.addr.ioView.regAddr];
         end
         rsp.nxm  = 1'b0;
         rsp.data = r.addr.ioView.flags.rd ? {18'd0, regVal} : 36'd0;   // Zero-extended
      end
      return rsp;
   endfunction

   // One level per bridge, from the shadow CSRs
   function automatic ks10Pkg::intrVec_t refIntr();
      ks10Pkg::intrVec_t v;
      logic [17:0]       csrs [2];
      logic [2:0]        lvl;
      csrs[0] = shadowIo1[0];
      csrs[1] = shadowIo3[0];
      v = '0;
      for (int b = 0; b < 2; b++) begin
         lvl = csrs[b][ks10Pkg::csrLevelMsb:ks10Pkg::csrLevelLsb];
         if (csrs[b][ks10Pkg::csrIntEnable] && csrs[b][ks10Pkg::csrDone] && lvl != 3'd0) begin
            v[lvl - 1] = 1'b1;
         end
      end
      return v;
   endfunction

   // Shadow update for a write that a target serves
   task automatic applyWrite(input ks10Pkg::busReq_t r);
      if (!r.addr.memView.flags.io) begin
         if (r.addr.memView.wordAddr < `MEM_WORDS) begin
            shadowMem[r.addr.memView.wordAddr] = r.data;
         end
      end else if (r.addr.ioView.regAddr < `DEV_REGS) begin
         if (r.addr.ioView.ctlNum == `CTL_NUM1) shadowIo1[r.addr.ioView.regAddr] = r.data[17:0];
         if (r.addr.ioView.ctlNum == `CTL_NUM3) shadowIo3[r.addr.ioView.regAddr] = r.data[17:0];
      end
   endtask

   ////////////////////
   // Stimulus helpers

   function automatic ks10Pkg::busReq_t memWord(input logic wr, input logic [21:0] addr,
                                                input logic [35:0] data);
      ks10Pkg::busReq_t r;
      r = '0;
      r.addr.memView.flags.rd = !wr;
      r.addr.memView.flags.wr = wr;
      r.addr.memView.wordAddr = addr;
      r.data = data;
      return r;
   endfunction

   function automatic ks10Pkg::busReq_t ioWord(input logic wr, input logic [3:0] ctl,
                                               input logic [17:0] regAddr,
                                               input logic [35:0] data);
      ks10Pkg::busReq_t r;
      r = '0;
      r.addr.ioView.flags.rd = !wr;
      r.addr.ioView.flags.wr = wr;
      r.addr.ioView.flags.io = 1'b1;
      r.addr.ioView.ctlNum   = ctl;
      r.addr.ioView.regAddr  = regAddr;
      r.data = data;
      return r;
   endfunction

   function automatic logic [35:0] randWord();
      logic [63:0] raw;
      raw = {$random(seed), $random(seed)};
      return raw[35:0];
   endfunction

   // CSR with done set, level and enable as given
   function automatic logic [35:0] csrWord(input logic [2:0] level, input logic enable);
      logic [35:0] w;
      w = 36'd0;
      w[ks10Pkg::csrLevelMsb:ks10Pkg::csrLevelLsb] = level;
      w[ks10Pkg::csrIntEnable] = enable;
      w[ks10Pkg::csrDone]      = 1'b1;
      return w;
   endfunction

   // Full four-phase cycle
   task automatic busCycle(input ks10Pkg::busReq_t r);
      expRspQ.push_back(refResponse(r));
      if (r.addr.memView.flags.wr) applyWrite(r);
      @(posedge clk);
      req     <= 1'b1;
      request <= r;
      do @(negedge clk); while (!ack);
      @(posedge clk);
      req <= 1'b0;
      do @(negedge clk); while (ack);   // Release done
   endtask

   task automatic checkValue(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
      if (actual !== expected) begin
         $display("ERROR at %0t ns: %s expected %0h, got %0h", $time, what, expected, actual);
         $display("TEST FAIL");
         $fatal(1, "Value mismatch");
      end
   endtask

   task automatic pulseReset();
      @(posedge clk);
      reset <= 1'b1;
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
   endtask

   ////////////////////
   // Compare and watchdog

   // Every ack rise gets a response and interrupt check
   always @(negedge clk) begin
      ackRise = ack && !ackPrev;
      ackPrev = ack;
      if (ackRise && !req) begin
         $display("Handshake broken, ack rose while req was low at %0t ns", $time);
         $display("TEST FAIL");
         $fatal(1, "Handshake order");
      end else if (ackRise && expRspQ.size() == 0) begin
         $display("Unexpected ack with no transaction pending at %0t ns", $time);
         $display("TEST FAIL");
         $fatal(1, "Spurious ack");
      end else if (ackRise) begin
         checkValue(response, expRspQ.pop_front(), "bus response");
         checkValue(busIntr, refIntr(), "interrupt vector");
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycleLimit) begin
         $display("Timeout, the transactions did not finish within %0d cycles", cycleLimit);
         $display("TEST FAIL");
         $fatal(1, "Timeout");
      end
   end

   ////////////////////
   // Test sequence

   initial begin
      int addr;
      seed    = 73925;
      cycles  = 0;
      ackPrev = 1'b0;
      reset   = 1'b1;
      req     = 1'b0;
      request = '0;
      for (int i = 0; i < `DEV_REGS; i++) begin
         shadowIo1[i] = 18'd0;
         shadowIo3[i] = 18'd0;
      end
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      checkValue(ack, 0, "ack after reset");
      checkValue(busIntr, 0, "busIntr after reset");

      // Memory writes then reads
      for (int i = 0; i < numMem; i++) begin
         addr = {$random(seed)} % `MEM_WORDS;
         memAddrs.push_back(addr);
         busCycle(memWord(1'b1, addr, randWord()));
      end
      foreach (memAddrs[i]) busCycle(memWord(1'b0, memAddrs[i], 36'd0));

      // Bridge registers, interleaved so a leak shows up
      for (int i = 0; i < `DEV_REGS; i++) begin
         busCycle(ioWord(1'b1, `CTL_NUM1, i, randWord()));
         busCycle(ioWord(1'b1, `CTL_NUM3, i, randWord()));
      end
      for (int i = 0; i < `DEV_REGS; i++) begin
         busCycle(ioWord(1'b0, `CTL_NUM1, i, 36'd0));
         busCycle(ioWord(1'b0, `CTL_NUM3, i, 36'd0));
      end

      // Nobody answers
      busCycle(memWord(1'b0, `MEM_WORDS + ({$random(seed)} % 4096), 36'd0));
      busCycle(memWord(1'b1, 22'h3FFFFF, randWord()));
      busCycle(ioWord(1'b0, 4'd2, 18'd1, 36'd0));
      busCycle(ioWord(1'b0, `CTL_NUM1, `DEV_REGS, 36'd0));
      busCycle(ioWord(1'b1, `CTL_NUM3, `DEV_REGS + 5, randWord()));

      // Interrupt levels 3 and 5, then bridge 1 off
      busCycle(ioWord(1'b1, `CTL_NUM1, 18'd0, csrWord(3'd3, 1'b1)));
      busCycle(ioWord(1'b1, `CTL_NUM3, 18'd0, csrWord(3'd5, 1'b1)));
      checkValue(busIntr, 7'b0010100, "both bridge levels");
      busCycle(ioWord(1'b1, `CTL_NUM1, 18'd0, csrWord(3'd3, 1'b0)));
      checkValue(busIntr, 7'b0010000, "bridge 1 disabled");

      // Second reset, registers clear and memory stays
      pulseReset();
      for (int i = 0; i < `DEV_REGS; i++) begin
         shadowIo1[i] = 18'd0;
         shadowIo3[i] = 18'd0;
      end
      checkValue(ack, 0, "ack after second reset");
      checkValue(busIntr, 0, "busIntr after second reset");
      for (int i = 0; i < `DEV_REGS; i++) begin
         busCycle(ioWord(1'b0, `CTL_NUM1, i, 36'd0));
         busCycle(ioWord(1'b0, `CTL_NUM3, i, 36'd0));
      end
      foreach (memAddrs[i]) busCycle(memWord(1'b0, memAddrs[i], 36'd0));

      @(negedge clk);
      if (expRspQ.size() != 0) begin
         $display("Responses missing for %0d transactions", expRspQ.size());
         $display("TEST FAIL");
         $fatal(1, "Missing responses");
      end else begin
         $display("TEST PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== ks10Bus.f ====
+incdir+design
design/ks10Pkg.sv
design/busMemory.sv
design/ioBridge.sv
design/busArbiter.sv
design/ks10Bus.sv
sim/ks10BusTb.sv
